// ==== fpu_mult_pkg.sv ====
`default_nettype none

package fpu_mult_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Single precision field widths
    ////////////////////////////////////////////////////////////////////////////

    // Full IEEE word
    localparam int FLOAT_W  = 32;
    // Biased exponent field
    localparam int EXP_W    = 8;
    // Stored fraction, hidden one not counted
    localparam int MANT_W   = 23;
    localparam int EXP_BIAS = 127;

    typedef logic [FLOAT_W-1:0]    float_t;
    typedef logic [EXP_W-1:0]      exp_t;
    // Two extra bits for sums up to 510 and negative unbiased values
    typedef logic [EXP_W+1:0]      exp_wide_t;
    // Significand with hidden one
    typedef logic [MANT_W:0]       mant_t;
    typedef logic [2*MANT_W+1:0]   prod_t;
    typedef logic [1:0]            round_mode_t;

    // Rounding mode codes, 2'b11 falls back to truncate
    localparam round_mode_t ROUND_TRUNC   = 2'b00;
    localparam round_mode_t ROUND_POS_INF = 2'b01;
    localparam round_mode_t ROUND_NEG_INF = 2'b10;

    // Controller sequence, one state per datapath step
    typedef enum logic [3:0] {
        IDLE,
        LOAD_OPS,
        EXP_SUM,
        EXP_UNBIAS,
        NORMALIZE,
        ROUND,
        RENORM,
        PACK,
        DONE
    } mult_state_e;

endpackage

`default_nettype wire

// ==== fpu_mult_ctrl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface fpu_mult_ctrl_if;

    // Step strobes, one cycle each
    logic load_ops;
    logic exp_sum;
    logic exp_unbias;
    logic norm_step;
    logic round_step;
    logic renorm_step;
    logic pack_step;

    // Status back from the datapath
    logic zero_op;
    logic prod_msb;
    logic round_carry;

    modport ctrl (
        output load_ops, exp_sum, exp_unbias, norm_step,
        output round_step, renorm_step, pack_step,
        input  zero_op, prod_msb, round_carry
    );

    // Exponent side only listens
    modport exp (
        input load_ops, exp_sum, exp_unbias, norm_step, renorm_step,
        input prod_msb, round_carry
    );

    modport sgf (
        input  load_ops, exp_sum, norm_step, round_step, renorm_step,
        output prod_msb, round_carry
    );

    modport pack (
        input  load_ops, pack_step,
        output zero_op
    );

endinterface

`default_nettype wire

// ==== fpu_mult_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpu_mult_ctrl (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  logic            ack_i,
    output logic            ready_o,
    fpu_mult_ctrl_if.ctrl   ctrl
);

    import fpu_mult_pkg::*;

    mult_state_e state_q;
    mult_state_e state_d;

    ////////////////////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // start only looked at here
                if (start_i) begin
                    state_d = LOAD_OPS;
                end
            end
            LOAD_OPS:   state_d = EXP_SUM;
            // Zero or denormal operand skips straight to packing
            EXP_SUM:    state_d = ctrl.zero_op ? PACK : EXP_UNBIAS;
            EXP_UNBIAS: state_d = NORMALIZE;
            NORMALIZE:  state_d = ROUND;
            ROUND:      state_d = RENORM;
            // Always visited so latency stays fixed
            RENORM:     state_d = PACK;
            PACK:       state_d = DONE;
            DONE: begin
                // Hold result until acknowledged
                if (ack_i) begin
                    state_d = IDLE;
                end
            end
            default:    state_d = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobe decode
    ////////////////////////////////////////////////////////////////////////////

    assign ctrl.load_ops    = (state_q == LOAD_OPS);
    assign ctrl.exp_sum     = (state_q == EXP_SUM);
    assign ctrl.exp_unbias  = (state_q == EXP_UNBIAS);
    assign ctrl.norm_step   = (state_q == NORMALIZE);
    // Datapath decides whether to add
    assign ctrl.round_step  = (state_q == ROUND);
    assign ctrl.renorm_step = (state_q == RENORM);
    assign ctrl.pack_step   = (state_q == PACK);

    assign ready_o = (state_q == DONE);

    // Steps never overlap
    a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({ctrl.load_ops, ctrl.exp_sum, ctrl.exp_unbias, ctrl.norm_step,
                  ctrl.round_step, ctrl.renorm_step, ctrl.pack_step}));

    // Ready only once the final word is packed
    a_ready_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ready_o) |-> $past(ctrl.pack_step));

endmodule

`default_nettype wire

// ==== fpu_exp_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpu_exp_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  fpu_mult_pkg::exp_t      a_exp_i,
    input  fpu_mult_pkg::exp_t      b_exp_i,
    fpu_mult_ctrl_if.exp            ctrl,
    output fpu_mult_pkg::exp_wide_t exp_o
);

    import fpu_mult_pkg::*;

    exp_t      a_exp_q;
    exp_t      b_exp_q;
    exp_wide_t exp_q;
    logic      inc_en;

    // Operand exponent fields
    always_ff @(posedge clk_i) begin
        if (ctrl.load_ops) begin
            a_exp_q <= a_exp_i;
            b_exp_q <= b_exp_i;
        end
    end

    // Bump by one when the significand shifts right
    assign inc_en = (ctrl.norm_step && ctrl.prod_msb) ||
                    (ctrl.renorm_step && ctrl.round_carry);

    ////////////////////////////////////////////////////////////////////////////
    // Working exponent
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            exp_q <= '0;
        end else if (ctrl.exp_sum) begin
            // Both biased, result carries bias twice
            exp_q <= exp_wide_t'(a_exp_q) + exp_wide_t'(b_exp_q);
        end else if (ctrl.exp_unbias) begin
            // May go negative here
            exp_q <= exp_q - exp_wide_t'(EXP_BIAS);
        end else if (inc_en) begin
            exp_q <= exp_q + exp_wide_t'(1);
        end
    end

    // Range check happens at packing
    assign exp_o = exp_q;

endmodule

`default_nettype wire

// ==== fpu_sgf_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpu_sgf_datapath (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  fpu_mult_pkg::round_mode_t      round_mode_i,
    input  logic [fpu_mult_pkg::MANT_W-1:0] a_frac_i,
    input  logic [fpu_mult_pkg::MANT_W-1:0] b_frac_i,
    input  logic                           sign_i,
    fpu_mult_ctrl_if.sgf                   ctrl,
    output fpu_mult_pkg::mant_t            mant_o
);

    import fpu_mult_pkg::*;

    mant_t       a_mant_q;
    mant_t       b_mant_q;
    prod_t       prod_q;
    mant_t       mant_q;
    round_mode_t round_mode_q;
    logic        round_flag_q;
    logic        round_carry_q;
    logic        sticky;
    logic        round_up;
    mant_t       norm_mant;

    ////////////////////////////////////////////////////////////////////////////
    // Operand capture and product
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (ctrl.load_ops) begin
            // Restore hidden ones
            a_mant_q     <= {1'b1, a_frac_i};
            b_mant_q     <= {1'b1, b_frac_i};
            round_mode_q <= round_mode_i;
        end
        if (ctrl.exp_sum) begin
            prod_q <= a_mant_q * b_mant_q;
        end
    end

    // Product lies in [1,4), top bit set means shift by one
    assign ctrl.prod_msb = prod_q[2*MANT_W+1];

    // Upper 24 bits after the normalize shift
    assign norm_mant = ctrl.prod_msb ? prod_q[2*MANT_W+1:MANT_W+1]
                                     : prod_q[2*MANT_W:MANT_W];

    // Any bit dropped below the kept significand
    assign sticky = ctrl.prod_msb ? |prod_q[MANT_W:0]
                                  : |prod_q[MANT_W-1:0];

    // Directed rounding away from zero only on the matching sign
    assign round_up = ((round_mode_q == ROUND_POS_INF) && !sign_i) ||
                      ((round_mode_q == ROUND_NEG_INF) && sign_i);

    ////////////////////////////////////////////////////////////////////////////
    // Normalize, round, renormalize
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (ctrl.norm_step) begin
            mant_q <= norm_mant;
        end else if (ctrl.round_step) begin
            // Wraps to zero when carrying out
            mant_q <= mant_q + mant_t'(round_flag_q);
        end else if (ctrl.renorm_step && round_carry_q) begin
            mant_q <= {1'b1, mant_q[MANT_W:1]};
        end
    end

    // Round decision and carry
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            round_flag_q  <= 1'b0;
            round_carry_q <= 1'b0;
        end else if (ctrl.load_ops) begin
            round_flag_q  <= 1'b0;
            round_carry_q <= 1'b0;
        end else if (ctrl.norm_step) begin
            round_flag_q  <= sticky && round_up;
        end else if (ctrl.round_step) begin
            round_carry_q <= round_flag_q && (&mant_q);
        end
    end

    assign ctrl.round_carry = round_carry_q;
    assign mant_o           = mant_q;

    // Hidden bit restored once renormalized
    a_hidden_one: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ctrl.renorm_step |=> mant_q[MANT_W]);

endmodule

`default_nettype wire

// ==== fpu_result_pack.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpu_result_pack (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  fpu_mult_pkg::float_t    a_i,
    input  fpu_mult_pkg::float_t    b_i,
    fpu_mult_ctrl_if.pack           ctrl,
    input  fpu_mult_pkg::exp_wide_t exp_i,
    input  fpu_mult_pkg::mant_t     mant_i,
    output logic                    sign_o,
    output fpu_mult_pkg::float_t    result_o,
    output logic                    overflow_o,
    output logic                    underflow_o
);

    import fpu_mult_pkg::*;

    logic   sign_q;
    logic   zero_op_q;
    logic   exp_ovf;
    logic   exp_unf;
    float_t result_q;
    logic   overflow_q;
    logic   underflow_q;

    // Sign and zero operand taken from the raw inputs
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sign_q    <= 1'b0;
            zero_op_q <= 1'b0;
        end else if (ctrl.load_ops) begin
            sign_q    <= a_i[FLOAT_W-1] ^ b_i[FLOAT_W-1];
            // Denormals count as zero
            zero_op_q <= (a_i[FLOAT_W-2:MANT_W] == '0) || (b_i[FLOAT_W-2:MANT_W] == '0);
        end
    end

    // Signed range of the working exponent
    assign exp_ovf = $signed(exp_i) >= (2**EXP_W - 1);
    assign exp_unf = $signed(exp_i) <= 0;

    ////////////////////////////////////////////////////////////////////////////
    // Final word and flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_q    <= '0;
            overflow_q  <= 1'b0;
            underflow_q <= 1'b0;
        end else if (ctrl.pack_step) begin
            overflow_q  <= !zero_op_q && exp_ovf;
            underflow_q <= !zero_op_q && exp_unf;
            if (zero_op_q || exp_unf) begin
                result_q <= {sign_q, {(FLOAT_W-1){1'b0}}};
            end else if (exp_ovf) begin
                // Signed infinity
                result_q <= {sign_q, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
            end else begin
                result_q <= {sign_q, exp_i[EXP_W-1:0], mant_i[MANT_W-1:0]};
            end
        end
    end

    assign ctrl.zero_op = zero_op_q;
    assign sign_o       = sign_q;
    assign result_o     = result_q;
    assign overflow_o   = overflow_q;
    assign underflow_o  = underflow_q;

    a_flags_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(overflow_o && underflow_o));

endmodule

`default_nettype wire

// ==== fpu_multiplier.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpu_multiplier (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      start_i,
    input  logic                      ack_i,
    input  fpu_mult_pkg::float_t      a_i,
    input  fpu_mult_pkg::float_t      b_i,
    input  fpu_mult_pkg::round_mode_t round_mode_i,
    output logic                      ready_o,
    output fpu_mult_pkg::float_t      result_o,
    output logic                      overflow_o,
    output logic                      underflow_o
);

    import fpu_mult_pkg::*;

    // Datapath between the units
    exp_wide_t exp_w;
    mant_t     mant_w;
    logic      sign_w;

    // Step strobes and status
    fpu_mult_ctrl_if ctrl_if ();

    fpu_mult_ctrl u_ctrl (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (start_i),
        .ack_i   (ack_i),
        .ready_o (ready_o),
        .ctrl    (ctrl_if.ctrl)
    );

    fpu_exp_unit u_exp (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .a_exp_i (a_i[FLOAT_W-2:MANT_W]),
        .b_exp_i (b_i[FLOAT_W-2:MANT_W]),
        .ctrl    (ctrl_if.exp),
        .exp_o   (exp_w)
    );

    fpu_sgf_datapath u_sgf (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .round_mode_i (round_mode_i),
        .a_frac_i     (a_i[MANT_W-1:0]),
        .b_frac_i     (b_i[MANT_W-1:0]),
        .sign_i       (sign_w),
        .ctrl         (ctrl_if.sgf),
        .mant_o       (mant_w)
    );

    fpu_result_pack u_pack (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .ctrl        (ctrl_if.pack),
        .exp_i       (exp_w),
        .mant_i      (mant_w),
        .sign_o      (sign_w),
        .result_o    (result_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release on a rising edge, synchronous reset in the DUT
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_fpu_multiplier.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fpu_multiplier;

    import fpu_mult_pkg::*;

    localparam int RESET_CYCLES = 10;
    // 12 exact, 6 zero, 24 rounding, 6 range, 50 random, 2 handshake
    localparam int NUM_OPS      = 100;
    // 8 latency cycles plus start and ack overhead
    localparam int OP_CYCLES    = 8 + 6;
    localparam int HOLD_CYCLES  = 2 * 34;
    localparam int TIMEOUT      = RESET_CYCLES + NUM_OPS * OP_CYCLES + HOLD_CYCLES + 20;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        ack;
    float_t      a;
    float_t      b;
    round_mode_t round_mode;
    logic        ready;
    float_t      result;
    logic        overflow;
    logic        underflow;

    int          checks    = 0;
    int          errors    = 0;
    int          cycle_cnt = 0;
    logic [31:0] lfsr_q    = 32'h26c3_27f2;

    tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fpu_multiplier DUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .start_i      (start),
        .ack_i        (ack),
        .a_i          (a),
        .b_i          (b),
        .round_mode_i (round_mode),
        .ready_o      (ready),
        .result_o     (result),
        .overflow_o   (overflow),
        .underflow_o  (underflow)
    );

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and random source
    ////////////////////////////////////////////////////////////////////////////

    function automatic float_t model_mult(input float_t fa, input float_t fb,
                                          input round_mode_t mode,
                                          output logic ovf, output logic unf);
        logic        sign;
        int          ea;
        int          eb;
        int          e;
        logic [47:0] prod;
        logic [23:0] mant;
        logic        inexact;
        logic        up;
        sign = fa[31] ^ fb[31];
        ovf  = 1'b0;
        unf  = 1'b0;
        ea   = int'(fa[30:23]);
        eb   = int'(fb[30:23]);
        // Zero or denormal operand gives a signed zero with no flags
        if (ea == 0 || eb == 0) return {sign, 31'd0};
        prod = 48'({1'b1, fa[22:0]}) * 48'({1'b1, fb[22:0]});
        e    = ea + eb - 127;
        if (prod[47]) begin
            mant    = prod[47:24];
            inexact = |prod[23:0];
            e       = e + 1;
        end else begin
            mant    = prod[46:23];
            inexact = |prod[22:0];
        end
        // Directed modes step away from zero only on the matching sign
        up = inexact && ((mode == ROUND_POS_INF && !sign) || (mode == ROUND_NEG_INF && sign));
        if (up && mant == 24'hFF_FFFF) begin
            mant = 24'h80_0000;
            e    = e + 1;
        end else if (up) begin
            mant = mant + 24'd1;
        end
        if (e >= 255) begin
            ovf = 1'b1;
            return {sign, 8'hFF, 23'd0};
        end
        if (e <= 0) begin
            unf = 1'b1;
            return {sign, 31'd0};
        end
        return {sign, e[7:0], mant[22:0]};
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    task automatic random_float(output float_t f);
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] m;
        take_bits(1, s);
        e = 32'd0;
        // Redraw until the field is a normal exponent
        while (e == 32'd0 || e == 32'd255) take_bits(8, e);
        take_bits(23, m);
        f = {s[0], e[7:0], m[22:0]};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_float(input string name, input float_t got, input float_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error: latency got %0h expected %0h", got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Operation driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_op(input float_t op_a, input float_t op_b, input round_mode_t mode,
                          input int hold);
        float_t exp_res;
        logic   exp_ovf;
        logic   exp_unf;
        int     lat;
        int     exp_lat;
        int     i;
        exp_res = model_mult(op_a, op_b, mode, exp_ovf, exp_unf);
        // Zero operand skips the rounding steps
        exp_lat = (op_a[30:23] == 8'd0 || op_b[30:23] == 8'd0) ? 4 : 8;
        @(posedge clk);
        start      <= 1'b1;
        a          <= op_a;
        b          <= op_b;
        round_mode <= mode;
        @(posedge clk);
        start <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (ready !== 1'b1) begin
            lat++;
            @(negedge clk);
        end
        check_latency(lat, exp_lat);
        check_float("result_o", result, exp_res);
        check_flag("overflow_o", overflow, exp_ovf);
        check_flag("underflow_o", underflow, exp_unf);
        // Withhold ack and send a stray start with other operands first
        for (i = 0; i < hold; i++) begin
            @(posedge clk);
            start <= (i == 0);
            if (i == 0) begin
                a <= ~op_a;
                b <= ~op_b;
            end
            @(negedge clk);
            check_flag("ready_o", ready, 1'b1);
            check_float("result_o", result, exp_res);
            check_flag("overflow_o", overflow, exp_ovf);
            check_flag("underflow_o", underflow, exp_unf);
        end
        @(posedge clk);
        start <= 1'b0;
        ack   <= 1'b1;
        @(posedge clk);
        ack <= 1'b0;
        @(negedge clk);
        check_flag("ready_o", ready, 1'b0);
    endtask

    // Modes 00 to 11 where the last acts as truncate
    task automatic run_all_modes(input float_t op_a, input float_t op_b);
        int m;
        for (m = 0; m < 4; m++) run_op(op_a, op_b, round_mode_t'(m), 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_exact();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_flag("ready_o", ready, 1'b0);
        check_flag("overflow_o", overflow, 1'b0);
        check_flag("underflow_o", underflow, 1'b0);
        check_float("result_o", result, 32'h0);
        run_all_modes(32'h4000_0000, 32'h4040_0000);
        run_all_modes(32'hBFC0_0000, 32'h4080_0000);
        run_all_modes(32'h3F80_0000, 32'h3F80_0000);
        report_test("reset and exact products", e0);
    endtask

    task automatic test_zero_operands();
        int e0;
        e0 = errors;
        run_op(32'h0000_0000, 32'h4040_0000, ROUND_TRUNC, 0);
        run_op(32'h4040_0000, 32'h8000_0000, ROUND_POS_INF, 0);
        run_op(32'h8000_0000, 32'hC000_0000, ROUND_NEG_INF, 0);
        // Denormals
        run_op(32'h0000_0001, 32'h40A0_0000, ROUND_POS_INF, 0);
        run_op(32'hC000_0000, 32'h8040_0000, ROUND_NEG_INF, 0);
        run_op(32'h807F_FFFF, 32'h807F_FFFF, 2'b11, 0);
        report_test("zero and denormal operands", e0);
    endtask

    task automatic test_rounding();
        int   e0;
        int   s;
        logic o;
        logic u;
        e0 = errors;
        // Model anchors where the rounding carry lands on 2.0
        check_float("model_mult", model_mult(32'h3FFF_FFFE, 32'h3F80_0001, ROUND_POS_INF, o, u),
                    32'h4000_0000);
        check_float("model_mult", model_mult(32'h3FFF_FFFE, 32'h3F80_0001, ROUND_TRUNC, o, u),
                    32'h3FFF_FFFF);
        for (s = 0; s < 2; s++) begin
            run_all_modes({s[0], 31'h3FFF_FFFE}, 32'h3F80_0001);
            run_all_modes({s[0], 31'h3FFF_FFFF}, 32'h3F80_0001);
            run_all_modes({s[0], 31'h3F8C_CCCD}, 32'h3F8C_CCCD);
        end
        report_test("directed rounding", e0);
    endtask

    task automatic test_range();
        int e0;
        e0 = errors;
        run_op(32'h7F00_0000, 32'h7F00_0000, ROUND_TRUNC, 0);
        run_op(32'hFF00_0000, 32'h4000_0000, ROUND_NEG_INF, 0);
        // Largest finite and then pushed over by rounding
        run_op(32'h7F7F_FFFF, 32'h3F80_0000, ROUND_POS_INF, 0);
        run_op(32'h7F7F_FFFF, 32'h3F80_0001, ROUND_POS_INF, 0);
        run_op(32'h0080_0000, 32'h0080_0000, ROUND_TRUNC, 0);
        run_op(32'h8080_0000, 32'h3F00_0000, ROUND_NEG_INF, 0);
        report_test("overflow and underflow", e0);
    endtask

    task automatic test_random();
        int          e0;
        int          n;
        float_t      ra;
        float_t      rb;
        logic [31:0] rm;
        e0 = errors;
        for (n = 0; n < 50; n++) begin
            random_float(ra);
            random_float(rb);
            take_bits(2, rm);
            run_op(ra, rb, round_mode_t'(rm[1:0]), 0);
        end
        report_test("random operands", e0);
    endtask

    task automatic test_handshake();
        int          e0;
        logic [31:0] h;
        e0 = errors;
        take_bits(5, h);
        run_op(32'h4040_0000, 32'hBF8C_CCCD, ROUND_NEG_INF, int'(h) + 2);
        take_bits(5, h);
        run_op(32'h7F00_0000, 32'h7F00_0000, ROUND_TRUNC, int'(h) + 2);
        report_test("held acknowledge", e0);
    endtask

    initial begin
        start      = 1'b0;
        ack        = 1'b0;
        a          = '0;
        b          = '0;
        round_mode = ROUND_TRUNC;
        @(posedge clk);
        while (rst_n !== 1'b1) @(posedge clk);
        test_reset_exact();
        test_zero_operands();
        test_rounding();
        test_range();
        test_random();
        test_handshake();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
fpu_mult_pkg.sv
fpu_mult_ctrl_if.sv
fpu_mult_ctrl.sv
fpu_exp_unit.sv
fpu_sgf_datapath.sv
fpu_result_pack.sv
fpu_multiplier.sv
tb_clk_gen.sv
tb_fpu_multiplier.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fpu_multiplier
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
